/* run.sh */
#!/bin/sh
# build with Verilator and run, pass only when the pass message appears
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module kv_tb \
    -f verilog.f -o kv_sim &&
./obj_dir/kv_sim | tee /dev/stderr | grep -q "Verification passed" &&
echo "PASS" || { echo "FAIL"; exit 1; }

/* src/kv_consts.svh */
`ifndef KV_CONSTS_SVH
`define KV_CONSTS_SVH

// key store geometry
`define KV_NUM_KEYS 4
`define KV_NUM_DWORDS 8

// hardware clients on the write and read side
`define KV_NUM_WRITE 2
`define KV_NUM_READ 2

// index widths for entry and dword offset
`define KV_ENTRY_W 2
`define KV_OFFSET_W 3

// register bus word address width
`define KV_ADDR_W 8

// patterns written over unlocked dwords on a debug flush
`define KV_DEBUG_VALUE_0 32'hA5A5A5A5
`define KV_DEBUG_VALUE_1 32'h5A5A5A5A

`endif

/* src/kv_ctrl_if.sv */
`timescale 1ns/1ps
`include "kv_consts.svh"

interface kv_ctrl_if
    import kv_pkg::*;
();

    // from the register block
    kv_entry_ctrl_t [`KV_NUM_KEYS-1:0]                   ctrl;
    logic [`KV_NUM_KEYS-1:0]                             clear;
    logic                                                flush;
    logic [31:0]                                         flush_value;

    // metadata updates from accepted client writes
    logic [`KV_NUM_KEYS-1:0]                             meta_we;
    logic [`KV_NUM_KEYS-1:0][`KV_NUM_READ-1:0]           meta_dest_valid;
    logic [`KV_NUM_KEYS-1:0][`KV_OFFSET_W-1:0]           meta_last_dword;

    modport regs (
        output ctrl, clear, flush, flush_value,
        input  meta_we, meta_dest_valid, meta_last_dword
    );

    modport store (
        input  ctrl, clear, flush, flush_value,
        output meta_we, meta_dest_valid, meta_last_dword
    );

endinterface

/* src/kv_pkg.sv */
`include "kv_consts.svh"

package kv_pkg;

    // register group selected by a bus address
    typedef enum logic [1:0] {
        REG_NONE          = 2'd0,
        REG_KEY_CTRL      = 2'd1,
        REG_CLEAR_SECRETS = 2'd2
    } kv_reg_sel_e;

    // control and metadata of one key entry
    typedef struct packed {
        // blocks client writes, clear and flush
        logic                    lock_wr;
        // blocks client reads
        logic                    lock_use;
        // one bit per read client allowed to use the entry
        logic [`KV_NUM_READ-1:0] dest_valid;
        // offset of the most recent client write
        logic [`KV_OFFSET_W-1:0] last_dword;
    } kv_entry_ctrl_t;

endpackage

/* src/kv_read_port.sv */
`timescale 1ns/1ps
`include "kv_consts.svh"

module kv_read_port
    import kv_pkg::*;
#(
    parameter int CLIENT = 0
) (
    input  logic [`KV_ENTRY_W-1:0]                            rd_entry_i,
    input  logic [`KV_OFFSET_W-1:0]                           rd_offset_i,
    input  logic [`KV_NUM_KEYS-1:0][`KV_NUM_DWORDS-1:0][31:0] key_i,
    input  kv_entry_ctrl_t [`KV_NUM_KEYS-1:0]                 entry_ctrl_i,
    output logic [31:0]                                       rd_data_o,
    output logic                                              rd_err_o,
    output logic                                              rd_last_o
);

    logic [`KV_NUM_KEYS-1:0] entry_hit;
    logic [`KV_NUM_KEYS-1:0] entry_grant;

    // an entry is readable when not use-locked and this client is a destination
    always_comb begin
        for (int e = 0; e < `KV_NUM_KEYS; e++) begin
            entry_hit[e]   = (rd_entry_i == e);
            entry_grant[e] = entry_hit[e] & ~entry_ctrl_i[e].lock_use &
                             entry_ctrl_i[e].dest_valid[CLIENT];
        end
    end

    // AND-OR mux across all entries and dwords
    always_comb begin
        rd_data_o = '0;
        rd_err_o  = 1'b0;
        rd_last_o = 1'b0;
        for (int e = 0; e < `KV_NUM_KEYS; e++) begin
            for (int d = 0; d < `KV_NUM_DWORDS; d++) begin
                if (entry_grant[e] && (rd_offset_i == d)) begin
                    rd_data_o |= key_i[e][d];
                end
            end
            rd_err_o  |= entry_hit[e] & ~entry_grant[e];
            // flags the final dword of the last client write
            rd_last_o |= entry_hit[e] & (rd_offset_i == entry_ctrl_i[e].last_dword);
        end
    end

    // a rejected read must never leak key bits
    always_comb begin
        assert (!rd_err_o || (rd_data_o == '0))
            else $error("read client %0d returned data with an error", CLIENT);
    end

endmodule

/* src/kv_regs.sv */
`timescale 1ns/1ps
`include "kv_consts.svh"

module kv_regs
    import kv_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  req_i,
    input  logic                  write_i,
    input  logic [`KV_ADDR_W-1:0] addr_i,
    input  logic [31:0]           wdata_i,
    output logic [31:0]           rdata_o,
    output logic                  err_o,
    input  logic                  debug_unlock_i,
    kv_ctrl_if.regs               ctrl
);

    localparam logic [`KV_ADDR_W-1:0] ADDR_CLEAR_SECRETS = 'h10;

    kv_reg_sel_e                       reg_sel;
    logic [`KV_ENTRY_W-1:0]            sel_entry;
    logic                              reg_wr;
    logic [`KV_NUM_KEYS-1:0]           key_ctrl_wr;
    logic                              clear_secrets_wr;
    kv_entry_ctrl_t [`KV_NUM_KEYS-1:0] entry_q;
    logic                              sel_debug_q;
    logic                              sel_debug_d;
    logic [31:0]                       rdata_d;
    logic                              err_d;

    // KEY_CTRL occupies the lowest word addresses
    always_comb begin
        if (addr_i < `KV_NUM_KEYS) begin
            reg_sel = REG_KEY_CTRL;
        end else if (addr_i == ADDR_CLEAR_SECRETS) begin
            reg_sel = REG_CLEAR_SECRETS;
        end else begin
            reg_sel = REG_NONE;
        end
    end

    assign sel_entry        = addr_i[`KV_ENTRY_W-1:0];
    assign reg_wr           = req_i & write_i;
    assign clear_secrets_wr = reg_wr & (reg_sel == REG_CLEAR_SECRETS);

    always_comb begin
        for (int e = 0; e < `KV_NUM_KEYS; e++) begin
            key_ctrl_wr[e] = reg_wr & (reg_sel == REG_KEY_CTRL) & (sel_entry == e);
        end
    end

    // clear and flush act on the same edge as the bus write
    assign ctrl.clear = key_ctrl_wr & {`KV_NUM_KEYS{wdata_i[2]}};
    assign ctrl.flush = (clear_secrets_wr & wdata_i[0]) | debug_unlock_i;

    // pattern follows the select value being written in the same transfer
    assign sel_debug_d      = clear_secrets_wr ? wdata_i[1] : sel_debug_q;
    assign ctrl.flush_value = sel_debug_d ? `KV_DEBUG_VALUE_1 : `KV_DEBUG_VALUE_0;
    assign ctrl.ctrl        = entry_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            entry_q     <= '0;
            sel_debug_q <= 1'b0;
        end else begin
            sel_debug_q <= sel_debug_d;
            for (int e = 0; e < `KV_NUM_KEYS; e++) begin
                // locks are sticky until reset
                if (key_ctrl_wr[e] && wdata_i[0]) begin
                    entry_q[e].lock_wr <= 1'b1;
                end
                if (key_ctrl_wr[e] && wdata_i[1]) begin
                    entry_q[e].lock_use <= 1'b1;
                end
                // metadata is frozen together with the data of a locked entry
                if (!entry_q[e].lock_wr) begin
                    if (ctrl.clear[e]) begin
                        entry_q[e].dest_valid <= '0;
                        entry_q[e].last_dword <= '0;
                    end else if (ctrl.meta_we[e]) begin
                        entry_q[e].dest_valid <= ctrl.meta_dest_valid[e];
                        entry_q[e].last_dword <= ctrl.meta_last_dword[e];
                    end
                end
            end
        end
    end

    // clear and wr_debug_values always read back as zero
    always_comb begin
        rdata_d = '0;
        err_d   = 1'b0;
        case (reg_sel)
            REG_KEY_CTRL: begin
                rdata_d[0]                 = entry_q[sel_entry].lock_wr;
                rdata_d[1]                 = entry_q[sel_entry].lock_use;
                rdata_d[8 +: `KV_NUM_READ]  = entry_q[sel_entry].dest_valid;
                rdata_d[12 +: `KV_OFFSET_W] = entry_q[sel_entry].last_dword;
            end
            REG_CLEAR_SECRETS: begin
                rdata_d[1] = sel_debug_q;
            end
            default: begin
                err_d = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            rdata_o <= '0;
            err_o   <= 1'b0;
        end else if (req_i) begin
            rdata_o <= write_i ? '0 : rdata_d;
            err_o   <= err_d;
        end
    end

    for (genvar e = 0; e < `KV_NUM_KEYS; e++) begin : g_lock_chk
        assert property (@(posedge clk) disable iff (rst_i)
            entry_q[e].lock_wr |=> entry_q[e].lock_wr)
            else $error("lock_wr of entry %0d dropped outside reset", e);
    end

endmodule

/* src/kv_store.sv */
`timescale 1ns/1ps
`include "kv_consts.svh"

module kv_store (
    input  logic                                              clk,
    input  logic                                              rst_i,
    input  logic [`KV_NUM_WRITE-1:0]                          wr_en_i,
    input  logic [`KV_NUM_WRITE-1:0][`KV_ENTRY_W-1:0]         wr_entry_i,
    input  logic [`KV_NUM_WRITE-1:0][`KV_OFFSET_W-1:0]        wr_offset_i,
    input  logic [`KV_NUM_WRITE-1:0][31:0]                    wr_data_i,
    input  logic [`KV_NUM_WRITE-1:0][`KV_NUM_READ-1:0]        wr_dest_valid_i,
    output logic [`KV_NUM_WRITE-1:0]                          wr_err_o,
    output logic [`KV_NUM_KEYS-1:0][`KV_NUM_DWORDS-1:0][31:0] key_o,
    kv_ctrl_if.store                                          ctrl
);

    logic [`KV_NUM_WRITE-1:0]                          wr_locked;
    logic [`KV_NUM_WRITE-1:0]                          wr_accept;
    logic [`KV_NUM_KEYS-1:0][`KV_NUM_DWORDS-1:0][31:0] key_q;
    logic [`KV_NUM_KEYS-1:0][`KV_NUM_DWORDS-1:0][31:0] key_d;

    // a lower client index takes a shared entry and the other write is dropped
    always_comb begin
        for (int c = 0; c < `KV_NUM_WRITE; c++) begin
            wr_locked[c] = wr_en_i[c] & ctrl.ctrl[wr_entry_i[c]].lock_wr;
            wr_accept[c] = wr_en_i[c] & ~wr_locked[c];
            for (int p = 0; p < c; p++) begin
                if (wr_en_i[p] && (wr_entry_i[p] == wr_entry_i[c])) begin
                    wr_accept[c] = 1'b0;
                end
            end
        end
    end

    assign wr_err_o = wr_locked;

    // metadata of the accepted write for the register block to latch
    always_comb begin
        for (int e = 0; e < `KV_NUM_KEYS; e++) begin
            ctrl.meta_we[e]         = 1'b0;
            ctrl.meta_dest_valid[e] = '0;
            ctrl.meta_last_dword[e] = '0;
            for (int c = `KV_NUM_WRITE - 1; c >= 0; c--) begin
                if (wr_accept[c] && (wr_entry_i[c] == e)) begin
                    ctrl.meta_we[e]         = 1'b1;
                    ctrl.meta_dest_valid[e] = wr_dest_valid_i[c];
                    ctrl.meta_last_dword[e] = wr_offset_i[c];
                end
            end
        end
    end

    // lock holds, then clear, then debug flush, then client data
    always_comb begin
        key_d = key_q;
        for (int e = 0; e < `KV_NUM_KEYS; e++) begin
            for (int d = 0; d < `KV_NUM_DWORDS; d++) begin
                if (!ctrl.ctrl[e].lock_wr) begin
                    if (ctrl.clear[e]) begin
                        key_d[e][d] = '0;
                    end else if (ctrl.flush) begin
                        key_d[e][d] = ctrl.flush_value;
                    end else begin
                        for (int c = `KV_NUM_WRITE - 1; c >= 0; c--) begin
                            if (wr_accept[c] && (wr_entry_i[c] == e) &&
                                (wr_offset_i[c] == d)) begin
                                key_d[e][d] = wr_data_i[c];
                            end
                        end
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            key_q <= '0;
        end else begin
            key_q <= key_d;
        end
    end

    assign key_o = key_q;

    for (genvar e = 0; e < `KV_NUM_KEYS; e++) begin : g_lock_chk
        assert property (@(posedge clk) disable iff (rst_i)
            ctrl.ctrl[e].lock_wr |=> $stable(key_q[e]))
            else $error("write-locked entry %0d changed", e);
    end

endmodule

/* src/kv_top.sv */
`timescale 1ns/1ps
`include "kv_consts.svh"

module kv_top (
    input  logic                                        clk,
    input  logic                                        rst_i,

    // register bus
    input  logic                                        req_i,
    input  logic                                        write_i,
    input  logic [`KV_ADDR_W-1:0]                       addr_i,
    input  logic [31:0]                                 wdata_i,
    output logic [31:0]                                 rdata_o,
    output logic                                        err_o,
    input  logic                                        debug_unlock_i,

    // write clients
    input  logic [`KV_NUM_WRITE-1:0]                    wr_en_i,
    input  logic [`KV_NUM_WRITE-1:0][`KV_ENTRY_W-1:0]   wr_entry_i,
    input  logic [`KV_NUM_WRITE-1:0][`KV_OFFSET_W-1:0]  wr_offset_i,
    input  logic [`KV_NUM_WRITE-1:0][31:0]              wr_data_i,
    input  logic [`KV_NUM_WRITE-1:0][`KV_NUM_READ-1:0]  wr_dest_valid_i,
    output logic [`KV_NUM_WRITE-1:0]                    wr_err_o,

    // read clients
    input  logic [`KV_NUM_READ-1:0][`KV_ENTRY_W-1:0]    rd_entry_i,
    input  logic [`KV_NUM_READ-1:0][`KV_OFFSET_W-1:0]   rd_offset_i,
    output logic [`KV_NUM_READ-1:0][31:0]               rd_data_o,
    output logic [`KV_NUM_READ-1:0]                     rd_err_o,
    output logic [`KV_NUM_READ-1:0]                     rd_last_o
);

    logic [`KV_NUM_KEYS-1:0][`KV_NUM_DWORDS-1:0][31:0] key;

    kv_ctrl_if ctrl_if ();

    kv_regs kv_regs_i (
        .clk            (clk),
        .rst_i          (rst_i),
        .req_i          (req_i),
        .write_i        (write_i),
        .addr_i         (addr_i),
        .wdata_i        (wdata_i),
        .rdata_o        (rdata_o),
        .err_o          (err_o),
        .debug_unlock_i (debug_unlock_i),
        .ctrl           (ctrl_if.regs)
    );

    kv_store kv_store_i (
        .clk             (clk),
        .rst_i           (rst_i),
        .wr_en_i         (wr_en_i),
        .wr_entry_i      (wr_entry_i),
        .wr_offset_i     (wr_offset_i),
        .wr_data_i       (wr_data_i),
        .wr_dest_valid_i (wr_dest_valid_i),
        .wr_err_o        (wr_err_o),
        .key_o           (key),
        .ctrl            (ctrl_if.store)
    );

    // one qualified read mux per read client
    for (genvar c = 0; c < `KV_NUM_READ; c++) begin : g_rd
        kv_read_port #(
            .CLIENT (c)
        ) kv_read_port_i (
            .rd_entry_i   (rd_entry_i[c]),
            .rd_offset_i  (rd_offset_i[c]),
            .key_i        (key),
            .entry_ctrl_i (ctrl_if.ctrl),
            .rd_data_o    (rd_data_o[c]),
            .rd_err_o     (rd_err_o[c]),
            .rd_last_o    (rd_last_o[c])
        );
    end

endmodule

/* tb/kv_tb.sv */
`timescale 1ns/1ps
`include "kv_consts.svh"

module kv_tb;

    localparam int MAX_CYCLES = 20000;

    logic                                               clk;
    logic                                               rst_i;
    logic                                               req_i;
    logic                                               write_i;
    logic [`KV_ADDR_W-1:0]                              addr_i;
    logic [31:0]                                        wdata_i;
    logic [31:0]                                        rdata_o;
    logic                                               err_o;
    logic                                               debug_unlock_i;
    logic [`KV_NUM_WRITE-1:0]                           wr_en_i;
    logic [`KV_NUM_WRITE-1:0][`KV_ENTRY_W-1:0]          wr_entry_i;
    logic [`KV_NUM_WRITE-1:0][`KV_OFFSET_W-1:0]         wr_offset_i;
    logic [`KV_NUM_WRITE-1:0][31:0]                     wr_data_i;
    logic [`KV_NUM_WRITE-1:0][`KV_NUM_READ-1:0]         wr_dest_valid_i;
    logic [`KV_NUM_WRITE-1:0]                           wr_err_o;
    logic [`KV_NUM_READ-1:0][`KV_ENTRY_W-1:0]           rd_entry_i;
    logic [`KV_NUM_READ-1:0][`KV_OFFSET_W-1:0]          rd_offset_i;
    logic [`KV_NUM_READ-1:0][31:0]                      rd_data_o;
    logic [`KV_NUM_READ-1:0]                            rd_err_o;
    logic [`KV_NUM_READ-1:0]                            rd_last_o;

    // reference model of the key array and the entry control
    logic [31:0]             model_key [`KV_NUM_KEYS][`KV_NUM_DWORDS];
    logic [`KV_NUM_READ-1:0] model_dv [`KV_NUM_KEYS];
    logic [`KV_OFFSET_W-1:0] model_last [`KV_NUM_KEYS];
    logic                    model_lwr [`KV_NUM_KEYS];
    logic                    model_luse [`KV_NUM_KEYS];
    logic [15:0]             lfsr;
    logic [31:0]             w;
    logic [31:0]             rdata;
    logic                    rerr;
    string                   test_name;

    kv_top kv_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // bounds the whole run
    initial begin
        for (int i = 0; i < MAX_CYCLES; i++) @(posedge clk);
        $display("timeout: the test sequence did not finish within %0d cycles", MAX_CYCLES);
        $display("Verification failed");
        $fatal(1);
    end

    task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("FAILED %s %s expected %08h actual %08h", test_name, what, exp, act);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    // galois lfsr stepped once per bit taken
    task automatic rand_word(output logic [31:0] word);
        word = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
            word = {word[30:0], lfsr[0]};
        end
    endtask

    task automatic bus_write(input logic [`KV_ADDR_W-1:0] addr, input logic [31:0] data);
        req_i   = 1'b1;
        write_i = 1'b1;
        addr_i  = addr;
        wdata_i = data;
        step();
        req_i   = 1'b0;
        write_i = 1'b0;
        check_eq($sformatf("bus write err @%02h", addr), 32'd0, err_o);
    endtask

    task automatic bus_read(input logic [`KV_ADDR_W-1:0] addr, output logic [31:0] data,
                            output logic err);
        req_i   = 1'b1;
        write_i = 1'b0;
        addr_i  = addr;
        step();
        req_i = 1'b0;
        data  = rdata_o;
        err   = err_o;
    endtask

    task automatic client_write(input int c, input int e, input int d, input logic [31:0] data,
                                input logic [`KV_NUM_READ-1:0] dv);
        wr_en_i[c]         = 1'b1;
        wr_entry_i[c]      = e;
        wr_offset_i[c]     = d;
        wr_data_i[c]       = data;
        wr_dest_valid_i[c] = dv;
        #1;
        check_eq($sformatf("wr_err c%0d e%0d", c, e), model_lwr[e], wr_err_o[c]);
        step();
        wr_en_i[c] = 1'b0;
        if (!model_lwr[e]) begin
            model_key[e][d] = data;
            model_dv[e]     = dv;
            model_last[e]   = d;
        end
    endtask

    task automatic clear_entry(input int e);
        bus_write(e, 32'h4);
        if (!model_lwr[e]) begin
            for (int d = 0; d < `KV_NUM_DWORDS; d++) begin
                model_key[e][d] = '0;
            end
            model_dv[e]   = '0;
            model_last[e] = '0;
        end
    endtask

    task automatic flush_model(input logic [31:0] pattern);
        for (int e = 0; e < `KV_NUM_KEYS; e++) begin
            if (!model_lwr[e]) begin
                for (int d = 0; d < `KV_NUM_DWORDS; d++) begin
                    model_key[e][d] = pattern;
                end
            end
        end
    endtask

    task automatic check_ctrl(input int e);
        logic [31:0] exp;
        logic [31:0] data;
        logic        err;
        exp        = '0;
        exp[0]     = model_lwr[e];
        exp[1]     = model_luse[e];
        exp[9:8]   = model_dv[e];
        exp[14:12] = model_last[e];
        bus_read(e, data, err);
        check_eq($sformatf("key_ctrl[%0d]", e), exp, data);
        check_eq($sformatf("key_ctrl[%0d] err", e), 32'd0, err);
    endtask

    // each offset of one entry gets a cycle of its own and is checked on all read clients
    task automatic check_entry(input int e);
        logic bad;
        for (int d = 0; d < `KV_NUM_DWORDS; d++) begin
            for (int c = 0; c < `KV_NUM_READ; c++) begin
                rd_entry_i[c]  = e;
                rd_offset_i[c] = d;
            end
            #1;
            for (int c = 0; c < `KV_NUM_READ; c++) begin
                bad = model_luse[e] | ~model_dv[e][c];
                check_eq($sformatf("rd_err e%0d c%0d d%0d", e, c, d), bad, rd_err_o[c]);
                check_eq($sformatf("rd_data e%0d c%0d d%0d", e, c, d),
                         bad ? 32'd0 : model_key[e][d], rd_data_o[c]);
                check_eq($sformatf("rd_last e%0d c%0d d%0d", e, c, d),
                         d == model_last[e], rd_last_o[c]);
            end
            step();
        end
    endtask

    task automatic check_all();
        for (int e = 0; e < `KV_NUM_KEYS; e++) begin
            check_entry(e);
            check_ctrl(e);
        end
    endtask

    initial begin
        rst_i = 1'b1;
        {req_i, write_i, addr_i, wdata_i, debug_unlock_i} = '0;
        {wr_en_i, wr_entry_i, wr_offset_i, wr_data_i, wr_dest_valid_i} = '0;
        {rd_entry_i, rd_offset_i} = '0;
        lfsr = 16'd85;
        for (int e = 0; e < `KV_NUM_KEYS; e++) begin
            for (int d = 0; d < `KV_NUM_DWORDS; d++) begin
                model_key[e][d] = '0;
            end
            {model_dv[e], model_last[e], model_lwr[e], model_luse[e]} = '0;
        end
        for (int i = 0; i < 10; i++) @(posedge clk);
        #2;
        rst_i = 1'b0;

        test_name = "reset";
        check_all();
        bus_read(8'h10, rdata, rerr);
        check_eq("clear_secrets", 32'd0, rdata);
        check_eq("clear_secrets err", 32'd0, rerr);
        bus_read(8'h20, rdata, rerr);
        check_eq("unmapped err", 32'd1, rerr);

        // entry e gets dest_valid e+1 and a shorter run of offsets each time
        test_name = "write";
        for (int e = 0; e < 3; e++) begin
            for (int d = 0; d < `KV_NUM_DWORDS - 2 * e; d++) begin
                rand_word(w);
                client_write(d % 2, e, d, w, e + 1);
            end
        end
        check_all();

        test_name = "locks";
        bus_write(8'h00, 32'h2);
        model_luse[0] = 1'b1;
        bus_write(8'h02, 32'h1);
        model_lwr[2] = 1'b1;
        rand_word(w);
        client_write(1, 2, 0, w, 2'b11);
        bus_write(8'h00, 32'h0);
        bus_write(8'h02, 32'h0);
        check_all();

        test_name = "clear";
        clear_entry(1);
        clear_entry(2);
        check_all();

        test_name = "flush";
        bus_write(8'h10, 32'h1);
        flush_model(`KV_DEBUG_VALUE_0);
        check_all();
        for (int d = 0; d < 4; d++) begin
            rand_word(w);
            client_write(0, 1, d, w, 2'b11);
        end
        bus_write(8'h10, 32'h2);
        debug_unlock_i = 1'b1;
        step();
        debug_unlock_i = 1'b0;
        flush_model(`KV_DEBUG_VALUE_1);
        check_all();
        bus_read(8'h10, rdata, rerr);
        check_eq("clear_secrets sel", 32'h2, rdata);
        check_eq("clear_secrets sel err", 32'd0, rerr);

        $display("Verification passed");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+src
src/kv_pkg.sv
src/kv_ctrl_if.sv
src/kv_regs.sv
src/kv_store.sv
src/kv_read_port.sv
src/kv_top.sv
tb/kv_tb.sv
